// ==== u2_ctrl_pkg.sv ====
/* Radio core control path definitions
   Settings register map, field widths, reset values and FSM state types */

package u2_ctrl_pkg;

   ////////////////////
   // Bus widths
   ////////////////////

   // Wishbone byte address
   localparam int WB_AW  = 16;
   // Settings word address and payload
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   ////////////////////
   // Settings register map
   ////////////////////

   localparam logic [SET_AW-1:0] SR_CLK     = 8'd0;
   localparam logic [SET_AW-1:0] SR_SER     = 8'd1;
   localparam logic [SET_AW-1:0] SR_ADC     = 8'd2;
   localparam logic [SET_AW-1:0] SR_LED     = 8'd3;
   localparam logic [SET_AW-1:0] SR_PHY     = 8'd4;
   localparam logic [SET_AW-1:0] SR_LED_SRC = 8'd8;

   // Timer block, one-time count here and period at the next address
   localparam logic [SET_AW-1:0] SR_SIMTIMER = 8'd198;

   // Width of the byte-wide control registers
   localparam int CTRL_W = 8;

   // LED bits 1 to 4 start out under hardware control
   localparam logic [CTRL_W-1:0] LED_SRC_RESET = 8'b0001_1110;

   // Settings buffer holds 2**2 words
   localparam int FIFO_DEPTH_LOG = 2;

   ////////////////////
   // State types
   ////////////////////

   // Sender side of a four-phase req/ack link
   typedef enum logic [1:0] {
      HS_IDLE,
      HS_REQ,
      HS_WAIT_DROP
   } hs_state_t;

   // Bus cycle kind in the Wishbone slave
   typedef enum logic [1:0] {
      WB_IDLE,
      WB_WRITE,
      WB_READ
   } wb_op_t;

endpackage

// ==== set_if.sv ====
/* Settings write link
   One address/data word moved with a four-phase req/ack handshake */

`timescale 1ns/1ps

interface set_if import u2_ctrl_pkg::*; ();

   // Sender raises, receiver answers
   logic              req;
   logic              ack;

   // Held stable by the sender while req is high
   logic [SET_AW-1:0] addr;
   logic [SET_DW-1:0] data;

   modport sender (
      output req,
      output addr,
      output data,
      input  ack
   );

   modport receiver (
      input  req,
      input  addr,
      input  data,
      output ack
   );

endinterface

// ==== settings_bus.sv ====
/* Wishbone slave for the settings path
   Bus writes become handshaked settings words, reads return zero */

`timescale 1ns/1ps

module settings_bus import u2_ctrl_pkg::*; (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic [WB_AW-1:0]  adr_i,
   input  logic [SET_DW-1:0] dat_i,
   input  logic              we_i,
   input  logic              stb_i,
   input  logic              cyc_i,
   output logic              ack_o,
   output logic [SET_DW-1:0] dat_o,
   set_if.sender             wr
);

   wb_op_t    op;
   hs_state_t hs;
   logic      start;

   // New bus cycle only seen while idle
   assign start = (op == WB_IDLE) && cyc_i && stb_i;

   // Nothing readable on this slave
   assign dat_o = '0;

   ////////////////////
   // Bus and handshake FSM
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         op     <= WB_IDLE;
         hs     <= HS_IDLE;
         ack_o  <= 1'b0;
         wr.req <= 1'b0;
      end else begin
         // Ack is a single-cycle pulse
         ack_o <= 1'b0;
         case (op)
            WB_IDLE: begin
               if (start && we_i) begin
                  op     <= WB_WRITE;
                  hs     <= HS_REQ;
                  wr.req <= 1'b1;
               end else if (start) begin
                  op    <= WB_READ;
                  ack_o <= 1'b1;
               end
            end
            // Let the master drop stb before looking again
            WB_READ: op <= WB_IDLE;
            WB_WRITE: begin
               case (hs)
                  HS_REQ: begin
                     // Buffer took the word
                     if (wr.ack) begin
                        wr.req <= 1'b0;
                        ack_o  <= 1'b1;
                        hs     <= HS_WAIT_DROP;
                     end
                  end
                  HS_WAIT_DROP: begin
                     if (!wr.ack) begin
                        hs <= HS_IDLE;
                        op <= WB_IDLE;
                     end
                  end
                  default: begin
                     hs <= HS_IDLE;
                     op <= WB_IDLE;
                  end
               endcase
            end
            default: op <= WB_IDLE;
         endcase
      end
   end

   // Word address from byte address bits 9 to 2
   always_ff @(posedge wb_clk) begin
      if (start && we_i) begin
         wr.addr <= adr_i[9:2];
         wr.data <= dat_i;
      end
   end

endmodule

// ==== settings_fifo.sv ====
/* Settings write buffer
   Four-entry circular store with four-phase handshakes on both sides */

`timescale 1ns/1ps

module settings_fifo import u2_ctrl_pkg::*; (
   input  logic wb_clk,
   input  logic wb_rst,
   set_if.receiver wr,
   set_if.sender   rd
);

   // Address and data storage
   logic [SET_AW-1:0] addr_mem [0:(1<<FIFO_DEPTH_LOG)-1];
   logic [SET_DW-1:0] data_mem [0:(1<<FIFO_DEPTH_LOG)-1];

   logic [FIFO_DEPTH_LOG-1:0] wr_ptr;
   logic [FIFO_DEPTH_LOG-1:0] rd_ptr;
   // One extra bit so a full buffer can be told from an empty one
   logic [FIFO_DEPTH_LOG:0]   count;

   hs_state_t rd_state;
   logic      full;
   logic      empty;
   logic      push;
   logic      pop;

   assign full  = count[FIFO_DEPTH_LOG];
   assign empty = (count == '0);

   // Accept a new word only with room for it
   assign push = wr.req && !wr.ack && !full;
   // Oldest word leaves once the consumer answers
   assign pop  = (rd_state == HS_REQ) && rd.ack;

   // Head entry stays put while req is high
   assign rd.addr = addr_mem[rd_ptr];
   assign rd.data = data_mem[rd_ptr];

   always_ff @(posedge wb_clk) begin
      if (push) begin
         addr_mem[wr_ptr] <= wr.addr;
         data_mem[wr_ptr] <= wr.data;
      end
   end

   ////////////////////
   // Pointers and occupancy
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         wr.ack <= 1'b0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // Write side ack, held off while full
         if (push)
            wr.ack <= 1'b1;
         else if (!wr.req)
            wr.ack <= 1'b0;
      end
   end

   ////////////////////
   // Read side sender
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         rd_state <= HS_IDLE;
         rd.req   <= 1'b0;
      end else begin
         case (rd_state)
            HS_IDLE: begin
               if (!empty) begin
                  rd.req   <= 1'b1;
                  rd_state <= HS_REQ;
               end
            end
            HS_REQ: begin
               if (rd.ack) begin
                  rd.req   <= 1'b0;
                  rd_state <= HS_WAIT_DROP;
               end
            end
            HS_WAIT_DROP: begin
               // Go straight to the next word if one is waiting
               if (!rd.ack && !empty) begin
                  rd.req   <= 1'b1;
                  rd_state <= HS_REQ;
               end else if (!rd.ack) begin
                  rd_state <= HS_IDLE;
               end
            end
            default: rd_state <= HS_IDLE;
         endcase
      end
   end

endmodule

// ==== simple_timer.sv ====
/* Simple interrupt timer
   One-time and periodic single-cycle pulses, loaded through settings writes */

`timescale 1ns/1ps

module simple_timer import u2_ctrl_pkg::*; (
   input  logic              wb_clk,
   input  logic              wb_rst,
   input  logic              set_stb_i,
   input  logic [SET_AW-1:0] set_addr_i,
   input  logic [SET_DW-1:0] set_data_i,
   output logic              onetime_int_o,
   output logic              periodic_int_o
);

   logic [SET_DW-1:0] onetime_cnt;
   logic [SET_DW-1:0] period;
   logic [SET_DW-1:0] period_cnt;
   logic              load_onetime;
   logic              load_period;

   assign load_onetime = set_stb_i && (set_addr_i == SR_SIMTIMER);
   assign load_period  = set_stb_i && (set_addr_i == SR_SIMTIMER + 8'd1);

   // One-time countdown, zero means disarmed
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         onetime_cnt   <= '0;
         onetime_int_o <= 1'b0;
      end else if (load_onetime) begin
         onetime_cnt   <= set_data_i;
         onetime_int_o <= 1'b0;
      end else begin
         onetime_int_o <= (onetime_cnt == 32'd1);
         if (onetime_cnt != '0)
            onetime_cnt <= onetime_cnt - 1'b1;
      end
   end

   // Periodic counter reloads from the period register
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         period         <= '0;
         period_cnt     <= '0;
         periodic_int_o <= 1'b0;
      end else if (load_period) begin
         period         <= set_data_i;
         period_cnt     <= set_data_i;
         periodic_int_o <= 1'b0;
      end else if (period == '0) begin
         // Stopped
         periodic_int_o <= 1'b0;
      end else if (period_cnt == 32'd1) begin
         period_cnt     <= period;
         periodic_int_o <= 1'b1;
      end else begin
         period_cnt     <= period_cnt - 1'b1;
         periodic_int_o <= 1'b0;
      end
   end

endmodule

// ==== control_regs.sv ====
/* Settings register bank
   Drives clock, SERDES, ADC and PHY controls, the LED mux and the timer */

`timescale 1ns/1ps

module control_regs import u2_ctrl_pkg::*; (
   input  logic       wb_clk,
   input  logic       wb_rst,
   set_if.receiver    rd,
   // Hardware status
   input  logic       run_rx_i,
   input  logic       run_tx_i,
   input  logic       clk_status_i,
   input  logic       serdes_link_up_i,
   // Clock generator
   output logic       clock_ready_o,
   output logic [1:0] clk_en_o,
   output logic [1:0] clk_sel_o,
   // SERDES
   output logic       ser_enable_o,
   output logic       ser_prbsen_o,
   output logic       ser_loopen_o,
   output logic       ser_rx_en_o,
   // ADC
   output logic       adc_oe_a_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_b_o,
   output logic       adc_on_b_o,
   // Misc
   output logic       phy_reset_n_o,
   output logic [7:0] leds_o,
   output logic       onetime_int_o,
   output logic       periodic_int_o
);

   logic [CTRL_W-1:0] clk_reg;
   logic [CTRL_W-1:0] ser_reg;
   logic [CTRL_W-1:0] adc_reg;
   logic [CTRL_W-1:0] led_reg;
   logic [CTRL_W-1:0] led_src_reg;
   logic              phy_reg;
   logic [CTRL_W-1:0] led_hw;
   logic              take;

   // New word on the link this cycle
   assign take = rd.req && !rd.ack;

   ////////////////////
   // Register writes
   ////////////////////

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         rd.ack      <= 1'b0;
         clk_reg     <= '0;
         ser_reg     <= '0;
         adc_reg     <= '0;
         led_reg     <= '0;
         led_src_reg <= LED_SRC_RESET;
         phy_reg     <= 1'b0;
      end else begin
         // Ack follows req with one cycle of delay
         if (take)
            rd.ack <= 1'b1;
         else if (!rd.req)
            rd.ack <= 1'b0;
         if (take) begin
            case (rd.addr)
               SR_CLK:     clk_reg     <= rd.data[CTRL_W-1:0];
               SR_SER:     ser_reg     <= rd.data[CTRL_W-1:0];
               SR_ADC:     adc_reg     <= rd.data[CTRL_W-1:0];
               SR_LED:     led_reg     <= rd.data[CTRL_W-1:0];
               SR_PHY:     phy_reg     <= rd.data[0];
               SR_LED_SRC: led_src_reg <= rd.data[CTRL_W-1:0];
               // Timer decodes its own addresses
               default: ;
            endcase
         end
      end
   end

   ////////////////////
   // Output mapping
   ////////////////////

   assign {clock_ready_o, clk_en_o, clk_sel_o} = clk_reg[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = ser_reg[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_reg[3:0];

   // PHY held in reset while bit 0 set
   assign phy_reset_n_o = ~phy_reg;

   // Status word, bit 0 and top bits unused
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};

   // Source bit 1 picks hardware, 0 picks software
   assign leds_o = (led_src_reg & led_hw) | (~led_src_reg & led_reg);

   simple_timer timer_i (
      .wb_clk         (wb_clk),
      .wb_rst         (wb_rst),
      .set_stb_i      (take),
      .set_addr_i     (rd.addr),
      .set_data_i     (rd.data),
      .onetime_int_o  (onetime_int_o),
      .periodic_int_o (periodic_int_o)
   );

endmodule

// ==== u2_ctrl.sv ====
/* Radio core control path top level
   Wishbone slave, settings buffer and register bank on one clock */

`timescale 1ns/1ps

module u2_ctrl import u2_ctrl_pkg::*; (
   input  logic              wb_clk,
   input  logic              wb_rst,
   // Wishbone slave
   input  logic [WB_AW-1:0]  adr_i,
   input  logic [SET_DW-1:0] dat_i,
   input  logic              we_i,
   input  logic              stb_i,
   input  logic              cyc_i,
   output logic              ack_o,
   output logic [SET_DW-1:0] dat_o,
   // Status inputs
   input  logic              run_rx_i,
   input  logic              run_tx_i,
   input  logic              clk_status_i,
   input  logic              serdes_link_up_i,
   // Control outputs
   output logic              clock_ready_o,
   output logic [1:0]        clk_en_o,
   output logic [1:0]        clk_sel_o,
   output logic              ser_enable_o,
   output logic              ser_prbsen_o,
   output logic              ser_loopen_o,
   output logic              ser_rx_en_o,
   output logic              adc_oe_a_o,
   output logic              adc_on_a_o,
   output logic              adc_oe_b_o,
   output logic              adc_on_b_o,
   output logic              phy_reset_n_o,
   output logic [7:0]        leds_o,
   output logic              onetime_int_o,
   output logic              periodic_int_o
);

   // Bus to buffer, buffer to registers
   set_if wr ();
   set_if rd ();

   settings_bus settings_bus_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .adr_i  (adr_i),  .dat_i  (dat_i),
      .we_i   (we_i),   .stb_i  (stb_i),  .cyc_i (cyc_i),
      .ack_o  (ack_o),  .dat_o  (dat_o),
      .wr     (wr.sender)
   );

   settings_fifo settings_fifo_i (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .wr     (wr.receiver),
      .rd     (rd.sender)
   );

   control_regs control_regs_i (
      .wb_clk           (wb_clk),           .wb_rst         (wb_rst),
      .rd               (rd.receiver),
      .run_rx_i         (run_rx_i),         .run_tx_i       (run_tx_i),
      .clk_status_i     (clk_status_i),     .serdes_link_up_i (serdes_link_up_i),
      .clock_ready_o    (clock_ready_o),    .clk_en_o       (clk_en_o),
      .clk_sel_o        (clk_sel_o),
      .ser_enable_o     (ser_enable_o),     .ser_prbsen_o   (ser_prbsen_o),
      .ser_loopen_o     (ser_loopen_o),     .ser_rx_en_o    (ser_rx_en_o),
      .adc_oe_a_o       (adc_oe_a_o),       .adc_on_a_o     (adc_on_a_o),
      .adc_oe_b_o       (adc_oe_b_o),       .adc_on_b_o     (adc_on_b_o),
      .phy_reset_n_o    (phy_reset_n_o),    .leds_o         (leds_o),
      .onetime_int_o    (onetime_int_o),    .periodic_int_o (periodic_int_o)
   );

endmodule

// ==== u2_ctrl_checker.sv ====
/* Result checker for the radio core control path
   Shadow register model, output comparison and interrupt pulse timing */

`timescale 1ns/1ps

module u2_ctrl_checker import u2_ctrl_pkg::*; (
   input  logic              wb_clk,
   input  logic              wb_rst,
   // Wishbone as seen at the DUT
   input  logic [WB_AW-1:0]  bus_adr_i,
   input  logic [SET_DW-1:0] bus_wdat_i,
   input  logic              bus_we_i,
   input  logic              bus_stb_i,
   input  logic              bus_cyc_i,
   input  logic              bus_ack_i,
   input  logic [SET_DW-1:0] bus_rdat_i,
   // Status inputs
   input  logic              run_rx_i,
   input  logic              run_tx_i,
   input  logic              clk_status_i,
   input  logic              serdes_link_up_i,
   // DUT control outputs
   input  logic              clock_ready_i,
   input  logic [1:0]        clk_en_i,
   input  logic [1:0]        clk_sel_i,
   input  logic              ser_enable_i,
   input  logic              ser_prbsen_i,
   input  logic              ser_loopen_i,
   input  logic              ser_rx_en_i,
   input  logic              adc_oe_a_i,
   input  logic              adc_on_a_i,
   input  logic              adc_oe_b_i,
   input  logic              adc_on_b_i,
   input  logic              phy_reset_n_i,
   input  logic [7:0]        leds_i,
   input  logic              onetime_int_i,
   input  logic              periodic_int_i,
   // Check request from the stimulus side
   input  logic              check_i,
   output logic              check_done_o,
   output int                check_count_o,
   output int                fail_count_o,
   output int                error_count_o
);

   // Shadow copies of the settings registers
   logic [CTRL_W-1:0] sh_clk;
   logic [CTRL_W-1:0] sh_ser;
   logic [CTRL_W-1:0] sh_adc;
   logic [CTRL_W-1:0] sh_led;
   logic [CTRL_W-1:0] sh_led_src;
   logic              sh_phy;
   // Timer loads and pulse history
   logic [SET_DW-1:0] ot_load;
   logic [SET_DW-1:0] per_load;
   int                ot_ack;
   int                ot_pulses;
   int                ot_first;
   int                per_ack;
   int                per_pulses;
   int                per_last;
   logic              per_gap_bad;
   // Bus cycle in flight
   logic              pend_we;
   logic [SET_AW-1:0] pend_addr;
   logic [SET_DW-1:0] pend_data;
   int                cycle;
   int                wait_cnt;
   int                mism;

   task automatic reset_model();
      sh_clk      = '0;
      sh_ser      = '0;
      sh_adc      = '0;
      sh_led      = '0;
      sh_led_src  = LED_SRC_RESET;
      sh_phy      = 1'b0;
      ot_load     = '0;
      per_load    = '0;
      ot_ack      = 0;
      ot_pulses   = 0;
      ot_first    = 0;
      per_ack     = 0;
      per_pulses  = 0;
      per_last    = 0;
      per_gap_bad = 1'b0;
      pend_we     = 1'b0;
      wait_cnt    = 0;
      check_done_o = 1'b0;
   endtask

   task automatic apply_write(input logic [SET_AW-1:0] addr, input logic [SET_DW-1:0] data);
      case (addr)
         SR_CLK:     sh_clk     = data[CTRL_W-1:0];
         SR_SER:     sh_ser     = data[CTRL_W-1:0];
         SR_ADC:     sh_adc     = data[CTRL_W-1:0];
         SR_LED:     sh_led     = data[CTRL_W-1:0];
         SR_LED_SRC: sh_led_src = data[CTRL_W-1:0];
         SR_PHY:     sh_phy     = data[0];
         SR_SIMTIMER: begin
            ot_load   = data;
            ot_ack    = cycle;
            ot_pulses = 0;
         end
         SR_SIMTIMER + 8'd1: begin
            per_load    = data;
            per_ack     = cycle;
            per_pulses  = 0;
            per_gap_bad = 1'b0;
         end
         // Unmapped addresses leave everything alone
         default: ;
      endcase
   endtask

   task automatic expect_value(input string name, input logic [7:0] exp, input logic [7:0] got);
      if (got !== exp) begin
         $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, exp, got);
         mism++;
      end
   endtask

   ////////////////////
   // Bus and timer watch
   ////////////////////

   task automatic watch_bus();
      // Ack closes the cycle latched earlier
      if (bus_ack_i) begin
         if (pend_we) begin
            apply_write(pend_addr, pend_data);
         end else if (bus_rdat_i !== '0) begin
            $display("[FAIL] t=%0t dat_o expected 0 got %0h", $time, bus_rdat_i);
            mism++;
         end
      end
      if (bus_cyc_i && bus_stb_i) begin
         pend_we   = bus_we_i;
         pend_addr = bus_adr_i[9:2];
         pend_data = bus_wdat_i;
      end
   endtask

   task automatic watch_timer();
      if (onetime_int_i) begin
         if (ot_pulses == 0)
            ot_first = cycle;
         ot_pulses++;
      end
      // Pulses inside the write latency still belong to the old period
      if (periodic_int_i && cycle > per_ack + 16) begin
         if (per_pulses > 0 && cycle - per_last != int'(per_load))
            per_gap_bad = 1'b1;
         per_pulses++;
         per_last = cycle;
      end
   endtask

   ////////////////////
   // Output comparison
   ////////////////////

   task automatic compare_outputs();
      logic [7:0] hw;
      logic [7:0] exp_leds;
      int         i;
      int         delay;
      hw       = '0;
      hw[4]    = run_tx_i;
      hw[3]    = run_rx_i;
      hw[2]    = clk_status_i;
      hw[1]    = serdes_link_up_i;
      // Source bit set means hardware status drives the LED
      for (i = 0; i < 8; i++)
         exp_leds[i] = sh_led_src[i] ? hw[i] : sh_led[i];
      expect_value("clock_ready_o", 8'(sh_clk[4]), 8'(clock_ready_i));
      expect_value("clk_en_o", 8'(sh_clk[3:2]), 8'(clk_en_i));
      expect_value("clk_sel_o", 8'(sh_clk[1:0]), 8'(clk_sel_i));
      expect_value("ser_enable_o", 8'(sh_ser[3]), 8'(ser_enable_i));
      expect_value("ser_prbsen_o", 8'(sh_ser[2]), 8'(ser_prbsen_i));
      expect_value("ser_loopen_o", 8'(sh_ser[1]), 8'(ser_loopen_i));
      expect_value("ser_rx_en_o", 8'(sh_ser[0]), 8'(ser_rx_en_i));
      expect_value("adc_oe_a_o", 8'(sh_adc[3]), 8'(adc_oe_a_i));
      expect_value("adc_on_a_o", 8'(sh_adc[2]), 8'(adc_on_a_i));
      expect_value("adc_oe_b_o", 8'(sh_adc[1]), 8'(adc_oe_b_i));
      expect_value("adc_on_b_o", 8'(sh_adc[0]), 8'(adc_on_b_i));
      expect_value("phy_reset_n_o", 8'(!sh_phy), 8'(phy_reset_n_i));
      expect_value("leds_o", exp_leds, leds_i);
      // Interrupt lines quiet once nothing is pending
      if (ot_load == '0 || ot_pulses > 0)
         expect_value("onetime_int_o", 8'h00, 8'(onetime_int_i));
      if (per_load == '0)
         expect_value("periodic_int_o", 8'h00, 8'(periodic_int_i));
      delay = ot_first - ot_ack;
      if (ot_load != '0 && ot_pulses != 1) begin
         $display("One-time interrupt fired %0d times after a load of %0d, expected once",
                  ot_pulses, ot_load);
         mism++;
      end else if (ot_load != '0 && (delay < int'(ot_load) || delay > int'(ot_load) + 16)) begin
         $display("One-time interrupt came %0d cycles after the write, expected %0d to %0d",
                  delay, ot_load, ot_load + 16);
         mism++;
      end else if (ot_load == '0 && ot_pulses != 0) begin
         $display("One-time interrupt fired %0d times while disarmed", ot_pulses);
         mism++;
      end
      if (per_load != '0 && per_pulses < 5) begin
         $display("Periodic interrupt fired only %0d times with period %0d",
                  per_pulses, per_load);
         mism++;
      end
      if (per_load != '0 && per_gap_bad) begin
         $display("Periodic interrupt pulses were not %0d cycles apart", per_load);
         mism++;
      end
      if (per_load == '0 && per_pulses != 0) begin
         $display("Periodic interrupt fired %0d times while stopped", per_pulses);
         mism++;
      end
      check_count_o++;
      if (mism == 0) begin
         $display("[PASS] check %0d at t=%0t", check_count_o, $time);
      end else begin
         $display("Check %0d at t=%0t failed with %0d mismatches", check_count_o, $time, mism);
         fail_count_o++;
         error_count_o += mism;
      end
      mism = 0;
   endtask

   // One process on the falling edge so model and compare never race
   initial begin
      cycle         = 0;
      mism          = 0;
      check_count_o = 0;
      fail_count_o  = 0;
      error_count_o = 0;
      reset_model();
      forever begin
         @(negedge wb_clk);
         cycle++;
         if (wb_rst) begin
            reset_model();
         end else begin
            watch_bus();
            watch_timer();
            // Compare 16 cycles after the request, past the write latency
            if (wait_cnt > 0) begin
               wait_cnt--;
               if (wait_cnt == 0) begin
                  compare_outputs();
                  check_done_o = 1'b1;
               end
            end else if (check_i && !check_done_o) begin
               wait_cnt = 16;
            end else if (!check_i) begin
               check_done_o = 1'b0;
            end
         end
      end
   end

endmodule

// ==== tb_u2_ctrl.sv ====
/* Testbench for the radio core control path
   Applies a table of bus writes, reads, waits and status changes */

`timescale 1ns/1ps

module tb_u2_ctrl import u2_ctrl_pkg::*; ();

   localparam logic [31:0] TB_SEED = 32'h7a90e865;

   // Row kinds of the stimulus table
   typedef enum logic [1:0] {
      OP_WRITE,
      OP_READ,
      OP_IDLE,
      OP_STATUS
   } tb_op_t;

   // Idle rows keep a cycle count in data, status rows the four status bits
   typedef struct packed {
      tb_op_t            op;
      logic [SET_AW-1:0] addr;
      logic [SET_DW-1:0] data;
      logic              chk;
   } row_t;

   logic              wb_clk;
   logic              wb_rst;
   logic [WB_AW-1:0]  adr_i;
   logic [SET_DW-1:0] dat_i;
   logic              we_i;
   logic              stb_i;
   logic              cyc_i;
   logic              ack_o;
   logic [SET_DW-1:0] dat_o;
   logic              run_rx_i;
   logic              run_tx_i;
   logic              clk_status_i;
   logic              serdes_link_up_i;
   logic              clock_ready_o;
   logic [1:0]        clk_en_o;
   logic [1:0]        clk_sel_o;
   logic              ser_enable_o;
   logic              ser_prbsen_o;
   logic              ser_loopen_o;
   logic              ser_rx_en_o;
   logic              adc_oe_a_o;
   logic              adc_on_a_o;
   logic              adc_oe_b_o;
   logic              adc_on_b_o;
   logic              phy_reset_n_o;
   logic [7:0]        leds_o;
   logic              onetime_int_o;
   logic              periodic_int_o;
   // Checker handshake and results
   logic              check_req;
   logic              check_done;
   int                check_count;
   int                fail_count;
   int                error_count;

   row_t   rows[$];
   integer seed;
   int     cycles = 0;
   int     limit = 0;

   u2_ctrl u2_ctrl_i (.*);

   u2_ctrl_checker checker_i (
      .wb_clk           (wb_clk),
      .wb_rst           (wb_rst),
      .bus_adr_i        (adr_i),
      .bus_wdat_i       (dat_i),
      .bus_we_i         (we_i),
      .bus_stb_i        (stb_i),
      .bus_cyc_i        (cyc_i),
      .bus_ack_i        (ack_o),
      .bus_rdat_i       (dat_o),
      .run_rx_i         (run_rx_i),
      .run_tx_i         (run_tx_i),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .clock_ready_i    (clock_ready_o),
      .clk_en_i         (clk_en_o),
      .clk_sel_i        (clk_sel_o),
      .ser_enable_i     (ser_enable_o),
      .ser_prbsen_i     (ser_prbsen_o),
      .ser_loopen_i     (ser_loopen_o),
      .ser_rx_en_i      (ser_rx_en_o),
      .adc_oe_a_i       (adc_oe_a_o),
      .adc_on_a_i       (adc_on_a_o),
      .adc_oe_b_i       (adc_oe_b_o),
      .adc_on_b_i       (adc_on_b_o),
      .phy_reset_n_i    (phy_reset_n_o),
      .leds_i           (leds_o),
      .onetime_int_i    (onetime_int_o),
      .periodic_int_i   (periodic_int_o),
      .check_i          (check_req),
      .check_done_o     (check_done),
      .check_count_o    (check_count),
      .fail_count_o     (fail_count),
      .error_count_o    (error_count)
   );

   // 8 ns clock
   initial wb_clk = 1'b0;
   always #4 wb_clk = ~wb_clk;

   // Run limit from the table length
   always @(posedge wb_clk) begin
      cycles <= cycles + 1;
      if (limit > 0 && cycles >= limit) begin
         $display("Timeout: the run passed %0d cycles without finishing the table", limit);
         $display("ERRORS FOUND");
         $finish;
      end
   end

   ////////////////////
   // Table and row drivers
   ////////////////////

   task automatic add_row(input tb_op_t op, input logic [SET_AW-1:0] addr,
                          input logic [SET_DW-1:0] data, input logic chk);
      row_t r;
      r.op   = op;
      r.addr = addr;
      r.data = data;
      r.chk  = chk;
      rows.push_back(r);
   endtask

   task automatic build_table();
      logic [SET_AW-1:0] burst_addr [8];
      int                i;
      burst_addr = '{SR_CLK, SR_SER, SR_CLK, SR_ADC, SR_LED, SR_SER, SR_LED_SRC, SR_CLK};
      // Reset state
      add_row(OP_IDLE, 8'd0, 32'd2, 1'b1);
      // Register mapping, unmapped address and read
      add_row(OP_WRITE, SR_CLK, 32'h15, 1'b0);
      add_row(OP_WRITE, SR_SER, 32'h0a, 1'b0);
      add_row(OP_WRITE, SR_ADC, 32'h05, 1'b0);
      add_row(OP_WRITE, SR_PHY, 32'h01, 1'b1);
      add_row(OP_WRITE, 8'd5, 32'hff, 1'b1);
      add_row(OP_READ, SR_CLK, 32'd0, 1'b1);
      add_row(OP_WRITE, SR_PHY, 32'h00, 1'b0);
      add_row(OP_WRITE, SR_CLK, 32'h0a, 1'b1);
      // LED source mux
      add_row(OP_WRITE, SR_LED, 32'ha5, 1'b1);
      add_row(OP_STATUS, 8'd0, 32'b1010, 1'b1);
      add_row(OP_WRITE, SR_LED_SRC, 32'hf0, 1'b1);
      add_row(OP_STATUS, 8'd0, 32'b0101, 1'b1);
      // Back-to-back burst, checked after the last word
      for (i = 0; i < 8; i++)
         add_row(OP_WRITE, burst_addr[i], $random(seed), i == 7);
      // One-time then periodic interrupt
      add_row(OP_WRITE, SR_SIMTIMER, 32'd20, 1'b0);
      add_row(OP_IDLE, 8'd0, 32'd140, 1'b1);
      add_row(OP_WRITE, SR_SIMTIMER + 8'd1, 32'd12, 1'b0);
      add_row(OP_IDLE, 8'd0, 32'd100, 1'b1);
      add_row(OP_WRITE, SR_SIMTIMER + 8'd1, 32'd0, 1'b0);
      add_row(OP_IDLE, 8'd0, 32'd60, 1'b1);
   endtask

   // One classic Wishbone cycle, held until ack
   task automatic wishbone_access(input logic we, input logic [SET_AW-1:0] addr,
                                  input logic [SET_DW-1:0] data);
      adr_i = {{(WB_AW-SET_AW-2){1'b0}}, addr, 2'b00};
      dat_i = data;
      we_i  = we;
      cyc_i = 1'b1;
      stb_i = 1'b1;
      do begin
         @(posedge wb_clk);
         #1;
      end while (!ack_o);
      cyc_i = 1'b0;
      stb_i = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge wb_clk);
         #1;
      end
   endtask

   task automatic drive_status(input logic [3:0] s);
      run_tx_i         = s[3];
      run_rx_i         = s[2];
      clk_status_i     = s[1];
      serdes_link_up_i = s[0];
   endtask

   // Four-phase handshake with the checker
   task automatic request_check();
      check_req = 1'b1;
      while (!check_done) begin
         @(posedge wb_clk);
         #1;
      end
      check_req = 1'b0;
      while (check_done) begin
         @(posedge wb_clk);
         #1;
      end
   endtask

   task automatic apply_row(input row_t r);
      case (r.op)
         OP_WRITE:  wishbone_access(1'b1, r.addr, r.data);
         OP_READ:   wishbone_access(1'b0, r.addr, r.data);
         OP_IDLE:   idle_cycles(r.data);
         OP_STATUS: drive_status(r.data[3:0]);
         default: ;
      endcase
      if (r.chk)
         request_check();
   endtask

   initial begin
      seed      = TB_SEED;
      wb_rst    = 1'b1;
      adr_i     = '0;
      dat_i     = '0;
      we_i      = 1'b0;
      stb_i     = 1'b0;
      cyc_i     = 1'b0;
      check_req = 1'b0;
      drive_status(4'b0111);
      build_table();
      limit = rows.size() * 40 + 2000;
      repeat (10) @(posedge wb_clk);
      #1;
      wb_rst = 1'b0;
      foreach (rows[i])
         apply_row(rows[i]);
      $display("Checks run: %0d, checks failed: %0d, mismatches: %0d",
               check_count, fail_count, error_count);
      if (error_count == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

endmodule

// ==== u2_ctrl.f ====
u2_ctrl_pkg.sv
set_if.sv
settings_bus.sv
settings_fifo.sv
simple_timer.sv
control_regs.sv
u2_ctrl.sv
u2_ctrl_checker.sv
tb_u2_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the control path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f u2_ctrl.f \
   --top-module tb_u2_ctrl -o sim_u2_ctrl

out="$(./obj_dir/sim_u2_ctrl)"
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
   exit 0
else
   exit 1
fi
